// ==== logic/soc_pkg.sv ====
// shared bus widths, address map and struct types of the peripheral block
// slot 0 holds the control registers, slot n+1 holds switch n
package soc_pkg;

  localparam int ADR_W = 8;
  localparam int DAT_W = 32;
  localparam int LED_W = 8;

  // each slot spans 16 bytes, four 32-bit words
  localparam int SLOT_LSB = 4;
  localparam int SLOT_W   = 3;
  localparam int OFS_W    = SLOT_LSB - 2;

  // word offsets inside slot 0
  localparam logic [OFS_W-1:0] REG_LED      = 2'd0;
  localparam logic [OFS_W-1:0] REG_IRQ_EN   = 2'd1;
  localparam logic [OFS_W-1:0] REG_IRQ_PEND = 2'd2;

  // switch register: bit 0 level, bit 1 pending (write 1 to clear)
  localparam int SW_PEND_BIT = 1;

  typedef struct packed {
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic             ack;
    logic [DAT_W-1:0] rdt;
  } wb_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    logic [SLOT_W-1:0] slot;
    logic [OFS_W-1:0]  ofs;
    logic [DAT_W-1:0]  dat;
  } reg_access_t;

  typedef struct packed {
    logic pend;
    logic level;
  } sw_status_t;

endpackage

// ==== logic/wb_decoder.sv ====
// one request in flight; every request is acked one cycle after it is first seen
// address bits above the slot field make an access unmapped (acked, no effect)
`timescale 1ns/1ps

module wb_decoder #(
  parameter int N_SWITCHES = 3
) (
  input  logic                  i_wb_clk,
  input  logic                  i_rst_n,
  input  soc_pkg::wb_req_t      i_req,
  output logic                  o_ack,
  output soc_pkg::reg_access_t  o_access,
  output logic [N_SWITCHES-1:0] o_clr
);
  import soc_pkg::*;

  localparam int HI_LSB = SLOT_LSB + SLOT_W;

  logic accept;
  logic in_map;
  logic sw_clr;

  // no new request while the ack of the previous one is out
  assign accept = i_req.cyc && i_req.stb && !o_ack;
  assign in_map = (i_req.adr[ADR_W-1:HI_LSB] == '0);

  always_comb begin
    o_access.valid = accept && in_map;
    o_access.we    = i_req.we;
    o_access.slot  = i_req.adr[SLOT_LSB +: SLOT_W];
    o_access.ofs   = i_req.adr[2 +: OFS_W];
    o_access.dat   = i_req.dat;
  end

  // clear request: write to word 0 of a switch slot with the pending bit set
  assign sw_clr = o_access.valid && o_access.we && (o_access.ofs == '0)
                  && i_req.dat[SW_PEND_BIT];

  always_comb begin
    for (int i = 0; i < N_SWITCHES; i++) begin
      // switch i lives in slot i+1
      o_clr[i] = sw_clr && (o_access.slot == SLOT_W'(i + 1));
    end
  end

  always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= accept;
    end
  end

  // master holds stb through the ack cycle, a second ack would mean a double accept
  a_single_ack: assert property (
    @(posedge i_wb_clk) disable iff (!i_rst_n)
    o_ack |=> !o_ack
  );

endmodule

// ==== logic/switch_port.sv ====
// raw switch input is asynchronous; SYNC_STAGES flops plus one edge register
// any level change sets pending, a set in the same cycle as a clear wins
`timescale 1ns/1ps

module switch_port #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                i_wb_clk,
  input  logic                i_rst_n,
  input  logic                i_switch,
  input  logic                i_clr,
  output soc_pkg::sw_status_t o_status
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   level_q;
  logic                   pend_q;
  logic                   changed;

  // oldest stage is the synchronized level
  assign changed = sync_q[SYNC_STAGES-1] ^ level_q;

  always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q[0] <= i_switch;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      level_q <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      level_q <= sync_q[SYNC_STAGES-1];
      if (changed) begin
        pend_q <= 1'b1;
      end else if (i_clr) begin
        pend_q <= 1'b0;
      end
    end
  end

  assign o_status.level = level_q;
  assign o_status.pend  = pend_q;

  // pending only rises together with a new registered level
  a_pend_on_edge: assert property (
    @(posedge i_wb_clk) disable iff (!i_rst_n)
    $rose(pend_q) |-> (level_q != $past(level_q))
  );

endmodule

// ==== logic/sys_ctrl_regs.sv ====
// LED and interrupt-enable registers plus read mux; read data is zero outside acks
// pending register is read-only, clearing goes through the switch slots
`timescale 1ns/1ps

module sys_ctrl_regs #(
  parameter int N_SWITCHES = 3
) (
  input  logic                                   i_wb_clk,
  input  logic                                   i_rst_n,
  input  soc_pkg::reg_access_t                   i_access,
  input  soc_pkg::sw_status_t [N_SWITCHES-1:0]   i_status,
  output logic [soc_pkg::DAT_W-1:0]              o_rdt,
  output logic [soc_pkg::LED_W-1:0]              o_leds,
  output logic                                   o_interrupt
);
  import soc_pkg::*;

  logic [LED_W-1:0]      led_q;
  logic [N_SWITCHES-1:0] en_q;
  logic [N_SWITCHES-1:0] pend_vec;
  logic [DAT_W-1:0]      rd_mux;
  logic [DAT_W-1:0]      rdt_q;
  logic                  ctrl_wr;

  always_comb begin
    for (int i = 0; i < N_SWITCHES; i++) begin
      pend_vec[i] = i_status[i].pend;
    end
  end

  assign ctrl_wr = i_access.valid && i_access.we && (i_access.slot == '0);

  always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      led_q <= '0;
      en_q  <= '0;
    end else if (ctrl_wr) begin
      if (i_access.ofs == REG_LED) begin
        led_q <= i_access.dat[LED_W-1:0];
      end
      if (i_access.ofs == REG_IRQ_EN) begin
        en_q <= i_access.dat[N_SWITCHES-1:0];
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    if (i_access.slot == '0) begin
      case (i_access.ofs)
        REG_LED:      rd_mux = {{(DAT_W-LED_W){1'b0}}, led_q};
        REG_IRQ_EN:   rd_mux = {{(DAT_W-N_SWITCHES){1'b0}}, en_q};
        REG_IRQ_PEND: rd_mux = {{(DAT_W-N_SWITCHES){1'b0}}, pend_vec};
        default:      rd_mux = '0;
      endcase
    end else begin
      // switch i sits at word 0 of slot i+1
      for (int i = 0; i < N_SWITCHES; i++) begin
        if (i_access.slot == SLOT_W'(i + 1) && i_access.ofs == '0) begin
          rd_mux = {{(DAT_W-2){1'b0}}, i_status[i]};
        end
      end
    end
  end

  // loaded on the access pulse, lines up with the decoder's ack
  always_ff @(posedge i_wb_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rdt_q <= '0;
    end else begin
      rdt_q <= i_access.valid ? rd_mux : '0;
    end
  end

  assign o_rdt       = rdt_q;
  assign o_leds      = led_q;
  assign o_interrupt = |(pend_vec & en_q);

  // one access pulse per bus cycle, never two back to back
  a_single_access: assert property (
    @(posedge i_wb_clk) disable iff (!i_rst_n)
    i_access.valid |=> !i_access.valid
  );

endmodule

// ==== logic/periph_top.sv ====
// slow peripheral block: Wishbone classic slave, switch ports, LEDs and interrupt
// N_SWITCHES must fit the slot field, at most 7
`timescale 1ns/1ps

module periph_top #(
  parameter int N_SWITCHES  = 3,
  parameter int SYNC_STAGES = 2
) (
  input  logic                         i_wb_clk,
  input  logic                         i_rst_n,
  input  soc_pkg::wb_req_t             i_req,
  output soc_pkg::wb_rsp_t             o_rsp,
  input  logic [N_SWITCHES-1:0]        i_switches,
  output logic [soc_pkg::LED_W-1:0]    o_leds,
  output logic                         o_interrupt
);
  import soc_pkg::*;

  logic                              ack;
  reg_access_t                       access;
  logic        [N_SWITCHES-1:0]      clr;
  sw_status_t  [N_SWITCHES-1:0]      status;
  logic        [DAT_W-1:0]           rdt;

  wb_decoder #(
    .N_SWITCHES (N_SWITCHES)
  ) u_decoder (
    .i_wb_clk (i_wb_clk),
    .i_rst_n  (i_rst_n),
    .i_req    (i_req),
    .o_ack    (ack),
    .o_access (access),
    .o_clr    (clr)
  );

  // one port per switch, clear pulses in, status out
  for (genvar gi = 0; gi < N_SWITCHES; gi++) begin : g_sw
    switch_port #(
      .SYNC_STAGES (SYNC_STAGES)
    ) u_switch (
      .i_wb_clk (i_wb_clk),
      .i_rst_n  (i_rst_n),
      .i_switch (i_switches[gi]),
      .i_clr    (clr[gi]),
      .o_status (status[gi])
    );
  end

  sys_ctrl_regs #(
    .N_SWITCHES (N_SWITCHES)
  ) u_regs (
    .i_wb_clk    (i_wb_clk),
    .i_rst_n     (i_rst_n),
    .i_access    (access),
    .i_status    (status),
    .o_rdt       (rdt),
    .o_leds      (o_leds),
    .o_interrupt (o_interrupt)
  );

  assign o_rsp = '{ack: ack, rdt: rdt};

endmodule

// ==== tests/tb_model.svh ====
// register model of periph_top, included in the testbench module body
// slot is adr[6:4] and word adr[3:2]; any address with bit 7 set is unmapped
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [LED_W-1:0] m_leds    = '0;
logic [N_SW-1:0]  m_en      = '0;
logic [N_SW-1:0]  m_level   = '0;
logic [N_SW-1:0]  m_pend    = '0;
logic [31:0]      rng_state = 32'h0899_5f92;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s ^ (s << 13);
  x = x ^ (x >> 17);
  return x ^ (x << 5);
endfunction

function automatic logic [31:0] next_rand();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// read data expected from the model state
function automatic logic [DAT_W-1:0] expected_read(input logic [ADR_W-1:0] adr);
  int              slot;
  int              ofs;
  logic [N_SW-1:0] p;
  logic [N_SW-1:0] l;
  slot = int'(adr[6:4]);
  ofs  = int'(adr[3:2]);
  p    = m_pend >> (slot - 1);
  l    = m_level >> (slot - 1);
  if (adr[7]) return '0;
  if (slot == 0 && ofs == 0) return {24'd0, m_leds};
  if (slot == 0 && ofs == 1) return DAT_W'(m_en);
  if (slot == 0 && ofs == 2) return DAT_W'(m_pend);
  // switch n answers at word 0 of slot n+1
  if (slot >= 1 && slot <= N_SW && ofs == 0) return {30'd0, p[0], l[0]};
  return '0;
endfunction

// register side effects of a bus write
function automatic void model_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
  int slot;
  int ofs;
  slot = int'(adr[6:4]);
  ofs  = int'(adr[3:2]);
  if (!adr[7] && slot == 0 && ofs == 0) m_leds = dat[7:0];
  if (!adr[7] && slot == 0 && ofs == 1) m_en = dat[N_SW-1:0];
  // write of 1 to bit 1 of a switch word clears its pending flag
  if (!adr[7] && slot >= 1 && slot <= N_SW && ofs == 0 && dat[1])
    m_pend = m_pend & ~(N_SW'(1) << (slot - 1));
endfunction

`endif

// ==== tests/tb_periph_top.sv ====
// Wishbone stimulus on falling edges, read data and ports checked against a model
// switch inputs are compared only after they have passed the synchronizer
`timescale 1ns/1ps

module tb_periph_top;
  import soc_pkg::*;

  localparam int N_SW       = 3;
  // about 500 accesses of 2 cycles plus 86 settle waits of 6, with wide margin
  localparam int MAX_CYCLES = 20000;

  logic             wb_clk = 1'b0;
  logic             rst_n;
  wb_req_t          req;
  wb_rsp_t          rsp;
  logic [N_SW-1:0]  switches;
  logic [LED_W-1:0] leds;
  logic             irq;

  logic             chk_en     = 1'b0;
  logic             rd_active  = 1'b0;
  logic [DAT_W-1:0] exp_rdt    = '0;
  int               wait_cnt   = 0;
  int               mismatches = 0;
  int               cycles     = 0;

  `include "tb_model.svh"

  periph_top #(.N_SWITCHES(N_SW)) uut (
    .i_wb_clk    (wb_clk),
    .i_rst_n     (rst_n),
    .i_req       (req),
    .o_rsp       (rsp),
    .i_switches  (switches),
    .o_leds      (leds),
    .o_interrupt (irq)
  );

  always #50 wb_clk = ~wb_clk;

  // first failed check ends the run
  task automatic flag_error(input string msg);
    $display("%s", msg);
    mismatches = mismatches + 1;
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // one classic cycle, held from a falling edge until ack is seen
  task automatic bus_xfer(input logic we, input logic [ADR_W-1:0] adr,
                          input logic [DAT_W-1:0] dat);
    @(negedge wb_clk);
    rd_active = !we;
    exp_rdt   = expected_read(adr);
    req.cyc   = 1'b1;
    req.stb   = 1'b1;
    req.we    = we;
    req.adr   = adr;
    req.dat   = dat;
    do begin
      @(negedge wb_clk);
    end while (!rsp.ack);
    req.cyc = 1'b0;
    req.stb = 1'b0;
    req.we  = 1'b0;
    if (we) model_write(adr, dat);
  endtask

  // new switch pattern; model follows once the change is through the synchronizer
  task automatic set_switches(input logic [N_SW-1:0] val);
    @(negedge wb_clk);
    chk_en   = 1'b0;
    switches = val;
    repeat (5) @(negedge wb_clk);
    m_pend  = m_pend | (m_level ^ val);
    m_level = val;
    chk_en  = 1'b1;
  endtask

  // sampled before this edge's register updates land
  // the model itself only changes on falling edges
  always @(posedge wb_clk) begin
    if (rst_n) begin
      if (rsp.ack) begin
        assert (wait_cnt == 1)
          else flag_error($sformatf("ack came %0d cycles after the request, not 1", wait_cnt));
        assert (!rd_active || rsp.rdt == exp_rdt)
          else flag_error($sformatf("ERR o_rsp.rdt got %h exp %h at adr %h",
                                    rsp.rdt, exp_rdt, req.adr));
        wait_cnt = 0;
      end else if (req.cyc && req.stb) begin
        wait_cnt = wait_cnt + 1;
      end
      assert (!chk_en || leds == m_leds)
        else flag_error($sformatf("ERR o_leds got %h exp %h", leds, m_leds));
      assert (!chk_en || irq == |(m_pend & m_en))
        else flag_error($sformatf("ERR o_interrupt got %h exp %h", irq, |(m_pend & m_en)));
    end
  end

  always @(posedge wb_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $fatal(1, "simulation stopped by the timeout");
    end
  end

  initial begin
    rst_n    = 1'b0;
    req      = '0;
    switches = '0;
    repeat (10) @(negedge wb_clk);
    rst_n  = 1'b1;
    chk_en = 1'b1;
    // control registers after reset
    for (int a = 0; a < 12; a += 4) bus_xfer(1'b0, 8'(a), '0);
    // LED register with random values
    repeat (40) begin
      bus_xfer(1'b1, 8'h00, next_rand());
      bus_xfer(1'b0, 8'h00, '0);
    end
    // random switch patterns, interrupts still masked
    repeat (20) begin
      set_switches(N_SW'(next_rand()));
      for (int i = 1; i <= N_SW; i++) bus_xfer(1'b0, 8'(i * 16), '0);
      bus_xfer(1'b0, 8'h08, '0);
    end
    // all enabled and cleared, then one toggle raises the interrupt
    bus_xfer(1'b1, 8'h04, 32'((1 << N_SW) - 1));
    for (int i = 1; i <= N_SW; i++) bus_xfer(1'b1, 8'(i * 16), 32'h2);
    set_switches(m_level ^ N_SW'(1));
    bus_xfer(1'b0, 8'h08, '0);
    bus_xfer(1'b0, 8'h10, '0);
    // clear through the switch slot drops the interrupt
    bus_xfer(1'b1, 8'h10, 32'h2);
    bus_xfer(1'b0, 8'h10, '0);
    // masked switch still sets pending without an interrupt
    bus_xfer(1'b1, 8'h04, 32'((1 << N_SW) - 2));
    set_switches(m_level ^ N_SW'(1));
    bus_xfer(1'b0, 8'h08, '0);
    bus_xfer(1'b0, 8'h10, '0);
    // read every word address, then write each one with all flags pending and read back
    for (int a = 0; a < 256; a += 4) bus_xfer(1'b0, 8'(a), '0);
    for (int a = 0; a < 256; a += 4) begin
      set_switches(~m_level);
      bus_xfer(1'b1, 8'(a), next_rand());
      for (int c = 0; c < 12; c += 4) bus_xfer(1'b0, 8'(c), '0);
    end
    repeat (4) @(negedge wb_clk);
    if (mismatches == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+tests
logic/soc_pkg.sv
logic/wb_decoder.sv
logic/switch_port.sv
logic/sys_ctrl_regs.sv
logic/periph_top.sv
tests/tb_periph_top.sv

// ==== Makefile ====
# Verilator build of the peripheral testbench, every variable can be overridden
VERILATOR ?= verilator
TOP       ?= tb_periph_top
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully
SIM        = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
